/* verilog/trig_pkg.sv */
package trig_pkg;

    // detector geometry
    localparam int NCHAN      = 4;
    localparam int ADDRBITS   = 12;
    localparam int BUF_DEPTH  = 1 << ADDRBITS;
    localparam int WORD_BITS  = 16;
    localparam int META_BITS  = 8;
    // latency, offset, holdoff and prescale all share this width
    localparam int CFG_BITS   = 16;
    // output queue
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam logic [1:0] OUT_TAG = 2'b10;

    typedef logic [ADDRBITS-1:0]  addr_t;
    typedef logic [META_BITS-1:0] meta_t;
    typedef logic [CFG_BITS-1:0]  cfg_t;
    typedef logic [NCHAN-1:0]     chan_vec_t;
    typedef logic [WORD_BITS-1:0] trigout_t;

    // first word of a pair, flag set
    typedef struct packed {
        logic       valid;
        logic       spare;
        addr_t      addr;
        logic [1:0] unused;
    } trig_addr_view_t;

    // second word of a pair, flag clear
    typedef struct packed {
        logic       valid;
        logic [6:0] spare;
        meta_t      meta;
    } trig_meta_view_t;

    // same 16 bits, decoded by the state of the framer
    typedef union packed {
        trig_addr_view_t addr_w;
        trig_meta_view_t meta_w;
    } trig_word_u;

endpackage

/* verilog/readout_if.sv */
`timescale 1ns/1ns

interface readout_if;
    import trig_pkg::*;

    // high for the single cycle a slot is presented
    logic              rd_valid;
    // buffer address the slot was read from
    addr_t             rd_addr;
    // stored trigger bit of every channel
    chan_vec_t         rd_trig;
    meta_t [NCHAN-1:0] rd_meta;

    modport store (
        output rd_valid,
        output rd_addr,
        output rd_trig,
        output rd_meta
    );

    modport leveltwo (
        input rd_valid,
        input rd_addr,
        input rd_trig,
        input rd_meta
    );

endinterface

/* verilog/trig_word_former.sv */
`timescale 1ns/1ns

module trig_word_former (
    input  logic                                           sysclk_i,
    input  logic                                           runrst_i,
    input  logic [trig_pkg::NCHAN*trig_pkg::WORD_BITS-1:0] trigin_dat_i,
    input  logic                                           trigin_dat_valid_i,
    output trig_pkg::chan_vec_t                            chan_trig_o,
    output trig_pkg::addr_t [trig_pkg::NCHAN-1:0]          chan_addr_o,
    output trig_pkg::meta_t [trig_pkg::NCHAN-1:0]          chan_meta_o
);
    import trig_pkg::*;

    // one framer per channel, all sampled on the shared valid
    for (genvar c = 0; c < NCHAN; c++) begin : g_chan
        trig_word_u word;
        // set between the address word and its metadata word
        logic       pending;
        logic       take_addr;
        logic       take_meta;
        logic       trig_q;
        addr_t      addr_q;
        meta_t      meta_q;

        assign word = trigin_dat_i[c*WORD_BITS +: WORD_BITS];

        // new address words are ignored while a pair is open
        assign take_addr = trigin_dat_valid_i && word.addr_w.valid && !pending;
        // a metadata word with no address before it is dropped
        assign take_meta = trigin_dat_valid_i && !word.meta_w.valid && pending;

        always_ff @(posedge sysclk_i) begin
            if (runrst_i) begin
                pending <= 1'b0;
                trig_q  <= 1'b0;
            end else begin
                // strobe lasts one cycle
                trig_q <= take_meta;
                if (take_addr) begin
                    pending <= 1'b1;
                end else if (take_meta) begin
                    pending <= 1'b0;
                end
            end
        end

        // address held until the metadata arrives
        always_ff @(posedge sysclk_i) begin
            if (take_addr) begin
                addr_q <= word.addr_w.addr;
            end
            if (take_meta) begin
                meta_q <= word.meta_w.meta;
            end
        end

        assign chan_trig_o[c] = trig_q;
        assign chan_addr_o[c] = addr_q;
        assign chan_meta_o[c] = meta_q;
    end

endmodule

/* verilog/trig_run_ctrl.sv */
`timescale 1ns/1ns

module trig_run_ctrl (
    input  logic            sysclk_i,
    input  logic            runrst_i,
    input  logic            runstop_i,
    input  trig_pkg::cfg_t  trig_latency_i,
    input  trig_pkg::cfg_t  trig_offset_i,
    input  trig_pkg::cfg_t  trig_holdoff_i,
    output logic            running_o,
    output logic            rd_en_o,
    output trig_pkg::addr_t rd_addr_o,
    output trig_pkg::addr_t address_o,
    output trig_pkg::cfg_t  offset_o,
    output trig_pkg::cfg_t  holdoff_o
);
    import trig_pkg::*;

    cfg_t  latency_q;
    cfg_t  offset_q;
    cfg_t  holdoff_q;
    logic  runrst_q;
    logic  running;
    cfg_t  lat_cnt;
    addr_t cur_addr;
    addr_t rd_addr;

    // settings track the inputs while runrst_i is high
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            latency_q <= trig_latency_i;
            offset_q  <= trig_offset_i;
            holdoff_q <= trig_holdoff_i;
        end
    end

    // run starts the cycle after runrst_i is seen low
    always_ff @(posedge sysclk_i) begin
        runrst_q <= runrst_i;
        if (runrst_i) begin
            running <= 1'b0;
        end else if (runrst_q) begin
            running <= 1'b1;
        end else if (runstop_i) begin
            running <= 1'b0;
        end
    end

    // write-side time, 0 in the first running cycle
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || !running) begin
            cur_addr <= '0;
        end else begin
            cur_addr <= cur_addr + 1'b1;
        end
    end

    // latency wait saturates at the captured value
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || !running) begin
            lat_cnt <= '0;
        end else if (lat_cnt != latency_q) begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // reading starts once the wait equals the latency
    assign rd_en_o = running && (lat_cnt == latency_q);

    // readout trails the write time by the latency, mod buffer depth
    always_ff @(posedge sysclk_i) begin
        if (rd_en_o) begin
            rd_addr <= rd_addr + 1'b1;
        end else begin
            rd_addr <= '0;
        end
    end

    assign running_o = running;
    assign rd_addr_o = rd_addr;
    assign address_o = cur_addr;
    assign offset_o  = offset_q;
    assign holdoff_o = holdoff_q;

endmodule

/* verilog/trig_store.sv */
`timescale 1ns/1ns

module trig_store (
    input  logic                                  sysclk_i,
    input  logic                                  runrst_i,
    input  logic                                  running_i,
    input  trig_pkg::chan_vec_t                   chan_trig_i,
    input  trig_pkg::addr_t [trig_pkg::NCHAN-1:0] chan_addr_i,
    input  trig_pkg::meta_t [trig_pkg::NCHAN-1:0] chan_meta_i,
    input  logic                                  rd_en_i,
    input  trig_pkg::addr_t                       rd_addr_i,
    readout_if.store                              rd
);
    import trig_pkg::*;

    // slot flag, one cycle behind the readout address
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            rd.rd_valid <= 1'b0;
        end else begin
            rd.rd_valid <= rd_en_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (rd_en_i) begin
            rd.rd_addr <= rd_addr_i;
        end
    end

    for (genvar c = 0; c < NCHAN; c++) begin : g_chan
        // trigger bit sits above the metadata byte
        logic [META_BITS:0] mem [BUF_DEPTH] = '{default: '0};
        logic               trig_rd;
        meta_t              meta_rd;

        always_ff @(posedge sysclk_i) begin
            // read and clear, so a wrapped pass finds an empty entry
            if (rd_en_i) begin
                trig_rd        <= mem[rd_addr_i][META_BITS];
                meta_rd        <= mem[rd_addr_i][META_BITS-1:0];
                mem[rd_addr_i] <= '0;
            end
            // each channel writes at the address it supplied
            if (running_i && chan_trig_i[c]) begin
                mem[chan_addr_i[c]] <= {1'b1, chan_meta_i[c]};
            end
        end

        assign rd.rd_trig[c] = trig_rd;
        assign rd.rd_meta[c] = meta_rd;
    end

endmodule

/* verilog/leveltwo_holdoff.sv */
`timescale 1ns/1ns

module leveltwo_holdoff (
    input  logic                sysclk_i,
    input  logic                runrst_i,
    readout_if.leveltwo         rd,
    input  trig_pkg::chan_vec_t trigmask_i,
    input  logic                trigmask_update_i,
    input  logic                leveltwo_logictype_i,
    input  logic                rf_en_i,
    input  trig_pkg::cfg_t      offset_i,
    input  trig_pkg::cfg_t      holdoff_i,
    output logic                fire_o,
    output trig_pkg::addr_t     fire_addr_o,
    output logic                held_off_o
);
    import trig_pkg::*;

    // a set bit excludes its channel
    chan_vec_t mask_q = '0;
    logic      logic_or_q;
    logic      rf_en_q;
    chan_vec_t enabled;
    chan_vec_t hits;
    logic      or_hit;
    logic      and_hit;
    logic      l2_hit;
    logic      fire_d;
    cfg_t      hold_cnt;

    // mask may change mid-run on its strobe
    always_ff @(posedge sysclk_i) begin
        if (trigmask_update_i) begin
            mask_q <= trigmask_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            logic_or_q <= leveltwo_logictype_i;
            rf_en_q    <= rf_en_i;
        end
    end

    assign enabled = ~mask_q;
    assign hits    = rd.rd_trig & enabled;
    assign or_hit  = |hits;
    // AND mode needs at least one enabled channel
    assign and_hit = (|enabled) && (hits == enabled);
    assign l2_hit  = logic_or_q ? or_hit : and_hit;

    assign held_off_o = (hold_cnt != '0);
    assign fire_d     = rd.rd_valid && rf_en_q && l2_hit && !held_off_o;

    // countdown blocks the next holdoff slots after a fire
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            fire_o   <= 1'b0;
            hold_cnt <= '0;
        end else begin
            fire_o <= fire_d;
            if (fire_d) begin
                hold_cnt <= holdoff_i;
            end else if (held_off_o) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    // slot address less the offset
    always_ff @(posedge sysclk_i) begin
        if (fire_d) begin
            fire_addr_o <= rd.rd_addr - offset_i[ADDRBITS-1:0];
        end
    end

endmodule

/* verilog/trig_output_stage.sv */
`timescale 1ns/1ns

module trig_output_stage (
    input  logic               sysclk_i,
    input  logic               runrst_i,
    input  logic               fire_i,
    input  trig_pkg::addr_t    fire_addr_i,
    input  trig_pkg::cfg_t     photo_prescale_i,
    input  logic               photo_en_i,
    input  logic               trigout_tready_i,
    output trig_pkg::trigout_t trigout_tdata_o,
    output logic               trigout_tvalid_o,
    output logic               photoshutter_o
);
    import trig_pkg::*;

    trigout_t         fifo_mem [FIFO_DEPTH];
    // extra bit tells full from empty
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;
    cfg_t             prescale_q;
    logic             photo_en_q;
    cfg_t             photo_cnt;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    // fire into a full queue is lost
    assign push  = fire_i && !full;
    assign pop   = trigout_tvalid_o && trigout_tready_i;

    assign trigout_tvalid_o = !empty;
    assign trigout_tdata_o  = fifo_mem[rd_ptr[FIFO_AW-1:0]];

    // tag, address, two zero bits
    always_ff @(posedge sysclk_i) begin
        if (push) begin
            fifo_mem[wr_ptr[FIFO_AW-1:0]] <= {OUT_TAG, fire_addr_i, 2'b00};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // pulse on every prescale+1-th fire
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            prescale_q     <= photo_prescale_i;
            photo_en_q     <= photo_en_i;
            photo_cnt      <= '0;
            photoshutter_o <= 1'b0;
        end else begin
            photoshutter_o <= 1'b0;
            if (!photo_en_q) begin
                photo_cnt <= '0;
            end else if (fire_i) begin
                if (photo_cnt == prescale_q) begin
                    photo_cnt      <= '0;
                    photoshutter_o <= 1'b1;
                end else begin
                    photo_cnt <= photo_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/master_trig_top.sv */
`timescale 1ns/1ns

module master_trig_top (
    input  logic                                           sysclk_i,
    input  logic                                           runrst_i,
    input  logic                                           runstop_i,
    input  trig_pkg::cfg_t                                 trig_latency_i,
    input  trig_pkg::cfg_t                                 trig_offset_i,
    input  trig_pkg::cfg_t                                 trig_holdoff_i,
    input  trig_pkg::chan_vec_t                            trigmask_i,
    input  logic                                           trigmask_update_i,
    input  logic                                           leveltwo_logictype_i,
    input  logic                                           rf_en_i,
    input  trig_pkg::cfg_t                                 photo_prescale_i,
    input  logic                                           photo_en_i,
    input  logic [trig_pkg::NCHAN*trig_pkg::WORD_BITS-1:0] trigin_dat_i,
    input  logic                                           trigin_dat_valid_i,
    input  logic                                           trigout_tready_i,
    output trig_pkg::trigout_t                             trigout_tdata_o,
    output logic                                           trigout_tvalid_o,
    output logic                                           photoshutter_o,
    output trig_pkg::addr_t                                address_o,
    output logic                                           running_o,
    output trig_pkg::chan_vec_t                            scal_trig_o,
    output logic                                           gpo_trig_d_o
);
    import trig_pkg::*;

    // framer to store
    chan_vec_t         chan_trig;
    addr_t [NCHAN-1:0] chan_addr;
    meta_t [NCHAN-1:0] chan_meta;
    // run control
    logic              running;
    logic              rd_en;
    addr_t             rd_addr;
    cfg_t              offset;
    cfg_t              holdoff;
    // level two to output
    logic              fire;
    addr_t             fire_addr;
    logic              held_off;

    readout_if u_readout ();

    trig_word_former u_former (
        .sysclk_i           (sysclk_i),
        .runrst_i           (runrst_i),
        .trigin_dat_i       (trigin_dat_i),
        .trigin_dat_valid_i (trigin_dat_valid_i),
        .chan_trig_o        (chan_trig),
        .chan_addr_o        (chan_addr),
        .chan_meta_o        (chan_meta)
    );

    trig_run_ctrl u_run_ctrl (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .runstop_i      (runstop_i),
        .trig_latency_i (trig_latency_i),
        .trig_offset_i  (trig_offset_i),
        .trig_holdoff_i (trig_holdoff_i),
        .running_o      (running),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .address_o      (address_o),
        .offset_o       (offset),
        .holdoff_o      (holdoff)
    );

    trig_store u_store (
        .sysclk_i    (sysclk_i),
        .runrst_i    (runrst_i),
        .running_i   (running),
        .chan_trig_i (chan_trig),
        .chan_addr_i (chan_addr),
        .chan_meta_i (chan_meta),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd          (u_readout.store)
    );

    leveltwo_holdoff u_leveltwo (
        .sysclk_i             (sysclk_i),
        .runrst_i             (runrst_i),
        .rd                   (u_readout.leveltwo),
        .trigmask_i           (trigmask_i),
        .trigmask_update_i    (trigmask_update_i),
        .leveltwo_logictype_i (leveltwo_logictype_i),
        .rf_en_i              (rf_en_i),
        .offset_i             (offset),
        .holdoff_i            (holdoff),
        .fire_o               (fire),
        .fire_addr_o          (fire_addr),
        .held_off_o           (held_off)
    );

    trig_output_stage u_output (
        .sysclk_i         (sysclk_i),
        .runrst_i         (runrst_i),
        .fire_i           (fire),
        .fire_addr_i      (fire_addr),
        .photo_prescale_i (photo_prescale_i),
        .photo_en_i       (photo_en_i),
        .trigout_tready_i (trigout_tready_i),
        .trigout_tdata_o  (trigout_tdata_o),
        .trigout_tvalid_o (trigout_tvalid_o),
        .photoshutter_o   (photoshutter_o)
    );

    // channel strobes double as scaler ticks
    assign scal_trig_o  = chan_trig;
    assign running_o    = running;
    assign gpo_trig_d_o = held_off;

endmodule

/* sim/master_trig_props.sv */
`timescale 1ns/1ns

module master_trig_props (
    input logic               sysclk_i,
    input logic               runrst_i,
    input logic               trigout_tvalid_o,
    input logic               trigout_tready_i,
    input trig_pkg::trigout_t trigout_tdata_o,
    input logic               photoshutter_o,
    input logic               fire_i,
    input trig_pkg::cfg_t     holdoff_i
);
    import trig_pkg::*;

    // cycles since the last fire, parked at the top after reset
    int since_fire;

    always @(posedge sysclk_i) begin
        if (runrst_i) begin
            since_fire <= 1 << CFG_BITS;
        end else if (fire_i) begin
            since_fire <= 0;
        end else if (since_fire < (1 << CFG_BITS)) begin
            since_fire <= since_fire + 1;
        end
    end

    // stream word waits with stable data until taken
    a_tvalid_hold: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        (trigout_tvalid_o && !trigout_tready_i) |=>
        (trigout_tvalid_o && $stable(trigout_tdata_o)))
        else $error("trigout dropped or changed before transfer");

    // two fires sit at least holdoff+1 slots apart
    a_holdoff_gap: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        fire_i |-> (since_fire >= int'(holdoff_i)))
        else $error("level-two fire inside the holdoff window");

    a_photo_pulse: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        photoshutter_o |=> !photoshutter_o)
        else $error("photoshutter high for two cycles");

endmodule

bind master_trig_top master_trig_props u_props (
    .sysclk_i         (sysclk_i),
    .runrst_i         (runrst_i),
    .trigout_tvalid_o (trigout_tvalid_o),
    .trigout_tready_i (trigout_tready_i),
    .trigout_tdata_o  (trigout_tdata_o),
    .photoshutter_o   (photoshutter_o),
    .fire_i           (fire),
    .holdoff_i        (holdoff)
);

/* sim/master_trig_tb.sv */
`timescale 1ns/1ns

module master_trig_tb;
    import trig_pkg::*;

    typedef struct packed {
        int        run;
        int        inj;
        chan_vec_t chans;
        addr_t     addr;
        meta_t     meta;
    } row_t;

    localparam int NROW = 15;
    localparam int LATENCY = 64;
    localparam int HOLDOFF = 4;
    localparam int OFFSET = 3;
    // slots from here on are judged with the second mask of a run
    localparam int MASK_SLOT = 600;

    // run, injection cycle, channels, buffer address, metadata (ascending address per run)
    localparam row_t ROWS [NROW] = '{
        '{0, 20, 4'b0001,  12'd200, 8'h11},
        '{0, 30, 4'b0110,  12'd202, 8'h22},
        '{0, 40, 4'b1000,  12'd210, 8'h33},
        '{0, 50, 4'b1111,  12'd215, 8'h44},
        '{0, 60, 4'b0010,  12'd400, 8'h55},
        '{0, 70, 4'b0100,  12'd405, 8'h66},
        '{0, 80, 4'b1001, 12'd1500, 8'h77},
        '{1, 20, 4'b0111,  12'd300, 8'h81},
        '{1, 30, 4'b1111,  12'd310, 8'h82},
        '{1, 40, 4'b0011,  12'd320, 8'h83},
        '{1, 50, 4'b1000,  12'd330, 8'h84},
        '{1, 60, 4'b0111,  12'd333, 8'h85},
        '{1, 70, 4'b0111,  12'd336, 8'h86},
        '{1, 90, 4'b0111,  12'd900, 8'h87},
        '{2, 20, 4'b1111,  12'd250, 8'h91}
    };

    logic                       sysclk_i = 1'b0;
    logic                       runrst_i = 1'b1;
    logic                       runstop_i = 1'b0;
    cfg_t                       trig_latency_i = cfg_t'(LATENCY);
    cfg_t                       trig_offset_i = cfg_t'(OFFSET);
    cfg_t                       trig_holdoff_i = cfg_t'(HOLDOFF);
    chan_vec_t                  trigmask_i = '0;
    logic                       trigmask_update_i = 1'b0;
    logic                       leveltwo_logictype_i = 1'b1;
    logic                       rf_en_i = 1'b1;
    cfg_t                       photo_prescale_i = 16'd1;
    logic                       photo_en_i = 1'b1;
    logic [NCHAN*WORD_BITS-1:0] trigin_dat_i = '0;
    logic                       trigin_dat_valid_i = 1'b0;
    logic                       trigout_tready_i = 1'b0;
    trigout_t                   trigout_tdata_o;
    logic                       trigout_tvalid_o;
    logic                       photoshutter_o;
    addr_t                      address_o;
    logic                       running_o;
    chan_vec_t                  scal_trig_o;
    logic                       gpo_trig_d_o;

    integer   seed = 32'h4cb975f9;
    trigout_t exp_q [$];
    int       pulses = 0;
    int       cyc = 0;
    int       limit = 0;

    master_trig_top i_dut (.*);

    always #10 sysclk_i = ~sysclk_i;

    task automatic stop_with(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, trigout_t act, trigout_t exp);
        if (act !== exp) begin
            stop_with($sformatf("FAIL %s got %h expected %h", name, act, exp));
        end
    endtask

    task automatic check_chan(string name, chan_vec_t act, chan_vec_t exp);
        if (act !== exp) begin
            stop_with($sformatf("FAIL %s got %h expected %h", name, act, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t act, addr_t exp);
        if (act !== exp) begin
            stop_with($sformatf("FAIL %s got %h expected %h", name, act, exp));
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            stop_with($sformatf("FAIL %s got %h expected %h", name, act, exp));
        end
    endtask

    task automatic check_count(string name, int act, int exp);
        if (act != exp) begin
            stop_with($sformatf("FAIL %s got %h expected %h", name, act, exp));
        end
    endtask

    // run-time limit restarts with every reset
    always @(posedge sysclk_i) begin
        if (runrst_i) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            if (limit != 0 && cyc > limit) begin
                stop_with("timeout waiting for the readout to finish");
            end
        end
    end

    // every transfer must match the head of the predicted queue
    always @(posedge sysclk_i) begin
        if (!runrst_i && trigout_tvalid_o && trigout_tready_i) begin
            if (exp_q.size() == 0) begin
                stop_with("an output word appeared that the model did not predict");
            end else begin
                check_word("trigout_tdata_o", trigout_tdata_o, exp_q.pop_front());
            end
        end
        if (!runrst_i && photoshutter_o) begin
            pulses <= pulses + 1;
        end
    end

    // random back-pressure
    always @(negedge sysclk_i) begin
        trigout_tready_i <= ($random(seed) & 3) != 0;
    end

    // walk the slots in address order and queue the predicted words
    function automatic int predict(int run, logic or_mode, chan_vec_t mask,
                                   chan_vec_t mask2, logic rf);
        chan_vec_t en;
        chan_vec_t hit;
        logic      l2;
        int        last;
        int        fires;
        last = -1000;
        fires = 0;
        for (int i = 0; i < NROW; i++) begin
            if (ROWS[i].run == run) begin
                // the mid-run mask strobe reaches slots from MASK_SLOT on
                en = (int'(ROWS[i].addr) >= MASK_SLOT) ? ~mask2 : ~mask;
                hit = ROWS[i].chans & en;
                l2 = or_mode ? (hit != 0) : ((en != 0) && (hit == en));
                // slots within holdoff after a fire are blocked
                if (rf && l2 && (int'(ROWS[i].addr) - last > HOLDOFF)) begin
                    last = int'(ROWS[i].addr);
                    exp_q.push_back({2'b10, addr_t'(ROWS[i].addr - OFFSET), 2'b00});
                    fires++;
                end
            end
        end
        return fires;
    endfunction

    // address word followed by a metadata word on each listed channel
    task automatic inject(chan_vec_t chans, addr_t addr, meta_t meta);
        for (int c = 0; c < NCHAN; c++) begin
            trigin_dat_i[c*WORD_BITS +: WORD_BITS] = chans[c] ? {2'b10, addr, 2'b00} : 16'h0;
        end
        trigin_dat_valid_i = 1'b1;
        @(negedge sysclk_i);
        for (int c = 0; c < NCHAN; c++) begin
            trigin_dat_i[c*WORD_BITS +: WORD_BITS] = chans[c] ? {8'h00, meta} : 16'h0;
        end
        @(negedge sysclk_i);
        trigin_dat_valid_i = 1'b0;
        trigin_dat_i = '0;
        check_chan("scal_trig_o", scal_trig_o, chans);
    endtask

    // metadata with no address before it frames nothing
    task automatic inject_lone(meta_t meta);
        trigin_dat_i = {48'h0, 8'h00, meta};
        trigin_dat_valid_i = 1'b1;
        @(negedge sysclk_i);
        trigin_dat_valid_i = 1'b0;
        trigin_dat_i = '0;
        check_chan("scal_trig_o", scal_trig_o, 4'b0000);
    endtask

    task automatic run_test(int run, logic or_mode, chan_vec_t mask, chan_vec_t mask2, logic rf);
        int fires;
        int base;
        int max_addr;
        @(negedge sysclk_i);
        runrst_i = 1'b1;
        leveltwo_logictype_i = or_mode;
        rf_en_i = rf;
        trigmask_i = mask;
        trigmask_update_i = 1'b1;
        repeat (8) @(negedge sysclk_i);
        check_bit("trigout_tvalid_o", trigout_tvalid_o, 1'b0);
        check_bit("photoshutter_o", photoshutter_o, 1'b0);
        check_bit("gpo_trig_d_o", gpo_trig_d_o, 1'b0);
        check_bit("running_o", running_o, 1'b0);
        check_chan("scal_trig_o", scal_trig_o, 4'b0000);
        runrst_i = 1'b0;
        trigmask_update_i = 1'b0;
        fires = predict(run, or_mode, mask, mask2, rf);
        base = pulses;
        max_addr = 0;
        // first running cycle starts the write time at zero
        @(negedge sysclk_i);
        check_bit("running_o", running_o, 1'b1);
        check_addr("address_o", address_o, '0);
        for (int i = 0; i < NROW; i++) begin
            if (ROWS[i].run == run) begin
                while (int'(address_o) < ROWS[i].inj) begin
                    @(negedge sysclk_i);
                end
                inject(ROWS[i].chans, ROWS[i].addr, ROWS[i].meta);
                if (int'(ROWS[i].addr) > max_addr) begin
                    max_addr = int'(ROWS[i].addr);
                end
            end
        end
        inject_lone(8'hee);
        // strobe lands between slot MASK_SLOT-1 and slot MASK_SLOT
        while (int'(address_o) < MASK_SLOT + LATENCY) begin
            @(negedge sysclk_i);
        end
        trigmask_i = mask2;
        trigmask_update_i = 1'b1;
        @(negedge sysclk_i);
        trigmask_update_i = 1'b0;
        // readout must have passed the last stored event
        while (int'(address_o) < max_addr + LATENCY + 8) begin
            @(negedge sysclk_i);
        end
        while (exp_q.size() != 0) begin
            @(negedge sysclk_i);
        end
        @(negedge sysclk_i);
        check_bit("trigout_tvalid_o", trigout_tvalid_o, 1'b0);
        // prescale 1 means a pulse on every second fire
        check_count("photoshutter pulses", pulses - base, fires / 2);
        // write time has stepped once in every cycle since the run began
        check_addr("address_o", address_o, addr_t'(cyc - 1));
        runstop_i = 1'b1;
        @(negedge sysclk_i);
        runstop_i = 1'b0;
        check_bit("running_o", running_o, 1'b0);
    endtask

    initial begin
        int last_inj;
        last_inj = 0;
        for (int i = 0; i < NROW; i++) begin
            if (ROWS[i].inj > last_inj) begin
                last_inj = ROWS[i].inj;
            end
        end
        limit = last_inj + LATENCY + 4096 + 200;
        // OR mode over all channels
        run_test(0, 1'b1, 4'b0000, 4'b0000, 1'b1);
        // AND mode with channel 3 masked off, all channels enabled from MASK_SLOT on
        run_test(1, 1'b0, 4'b1000, 4'b0000, 1'b1);
        // rf disabled so nothing may come out
        run_test(2, 1'b1, 4'b0000, 4'b0000, 1'b0);
        $display("test passed");
        $finish;
    end

endmodule

/* list.f */
verilog/trig_pkg.sv
verilog/readout_if.sv
verilog/trig_word_former.sv
verilog/trig_run_ctrl.sv
verilog/trig_store.sv
verilog/leveltwo_holdoff.sv
verilog/trig_output_stage.sv
verilog/master_trig_top.sv
sim/master_trig_props.sv
sim/master_trig_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := master_trig_tb
FILELIST  := list.f
OBJDIR    := obj_dir
SRCS      := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^test passed$$'

clean:
	rm -rf $(OBJDIR)
